//--- source/aes_inv_pkg.sv
//----------------------------------------------------------------------
// shared definitions for the block decipher core
// widths of block, word, byte and round index
// round counts and key length select value
// controller state and update command enums
// path of the inverse s-box table
//----------------------------------------------------------------------

package aes_inv_pkg;

  //--------------------------------------------------------------------
  // datapath widths
  //--------------------------------------------------------------------
  // full block, one column word, one byte
  localparam int block_width = 128;
  localparam int word_width  = 32;
  localparam int byte_width  = 8;

  // round index width, holds up to 14
  localparam int round_width = 4;

  //--------------------------------------------------------------------
  // round counts and key length
  //--------------------------------------------------------------------
  localparam logic [round_width-1:0] rounds_128 = 4'd10;
  localparam logic [round_width-1:0] rounds_256 = 4'd14;

  // keylen value for the long key
  localparam logic key_256 = 1'b1;

  //--------------------------------------------------------------------
  // controller states
  //--------------------------------------------------------------------
  typedef enum logic [1:0] {
    ctrl_idle = 2'h0,
    ctrl_init = 2'h1,
    ctrl_sbox = 2'h2,
    ctrl_main = 2'h3
  } ctrl_state_t;

  // command from controller to datapath, one per cycle
  typedef enum logic [2:0] {
    upd_none  = 3'h0,
    upd_init  = 3'h1,
    upd_sbox  = 3'h2,
    upd_main  = 3'h3,
    upd_final = 3'h4
  } update_t;

  // inverse s-box contents, 16 bytes per line
  localparam string sbox_file = "source/inv_sbox.hex";

endpackage

//--- source/inv_sbox_word.sv
//----------------------------------------------------------------------
// inverse s-box substitution of one 32-bit word
// four parallel byte lookups into a 256-entry table
//----------------------------------------------------------------------

`timescale 1ns/1ps

module inv_sbox_word
  import aes_inv_pkg::*;
(
  input  logic [word_width-1:0] sboxw,
  output logic [word_width-1:0] new_sboxw
);

  // table rom, filled once from the hex file
  logic [byte_width-1:0] sbox_mem [0:255];

  initial
  begin
    $readmemh(sbox_file, sbox_mem);
  end

  // each byte lane looked up on its own, lane 0 is the lsb byte
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      new_sboxw[i*byte_width +: byte_width] = sbox_mem[sboxw[i*byte_width +: byte_width]];
    end
  end

endmodule

//--- source/inv_round_datapath.sv
//----------------------------------------------------------------------
// decipher block state register and round transforms
// init, word-wise s-box, main and final updates
// inverse shift rows, inverse mix columns, add round key
//----------------------------------------------------------------------

`timescale 1ns/1ps

module inv_round_datapath
  import aes_inv_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   zeroize,
  input  update_t                update,
  input  logic [1:0]             sword,
  input  logic [block_width-1:0] round_key,
  input  logic [block_width-1:0] block_msg,
  output logic [block_width-1:0] new_block
);

  //--------------------------------------------------------------------
  // gf(2^8) helpers for inverse mix columns
  //--------------------------------------------------------------------
  // multiply by x, reduce by the field polynomial
  function automatic logic [byte_width-1:0] gm2(input logic [byte_width-1:0] op);
    gm2 = {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  function automatic logic [byte_width-1:0] gm8(input logic [byte_width-1:0] op);
    gm8 = gm2(gm2(gm2(op)));
  endfunction

  // 9, 11, 13 and 14 built from x, x^2 and x^3 terms
  function automatic logic [byte_width-1:0] gm09(input logic [byte_width-1:0] op);
    gm09 = gm8(op) ^ op;
  endfunction

  function automatic logic [byte_width-1:0] gm11(input logic [byte_width-1:0] op);
    gm11 = gm8(op) ^ gm2(op) ^ op;
  endfunction

  function automatic logic [byte_width-1:0] gm13(input logic [byte_width-1:0] op);
    gm13 = gm8(op) ^ gm2(gm2(op)) ^ op;
  endfunction

  function automatic logic [byte_width-1:0] gm14(input logic [byte_width-1:0] op);
    gm14 = gm8(op) ^ gm2(gm2(op)) ^ gm2(op);
  endfunction

  // one column through the inverse mix matrix
  function automatic logic [word_width-1:0] inv_mixw(input logic [word_width-1:0] w);
    logic [byte_width-1:0] b0;
    logic [byte_width-1:0] b1;
    logic [byte_width-1:0] b2;
    logic [byte_width-1:0] b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    inv_mixw = {gm14(b0) ^ gm11(b1) ^ gm13(b2) ^ gm09(b3),
                gm09(b0) ^ gm14(b1) ^ gm11(b2) ^ gm13(b3),
                gm13(b0) ^ gm09(b1) ^ gm14(b2) ^ gm11(b3),
                gm11(b0) ^ gm13(b1) ^ gm09(b2) ^ gm14(b3)};
  endfunction

  function automatic logic [block_width-1:0] inv_mixcolumns(input logic [block_width-1:0] d);
    inv_mixcolumns = {inv_mixw(d[127:96]), inv_mixw(d[95:64]),
                      inv_mixw(d[63:32]), inv_mixw(d[31:0])};
  endfunction

  //--------------------------------------------------------------------
  // row shift and key add
  //--------------------------------------------------------------------
  // row r of each column comes from the column r places to the left
  function automatic logic [block_width-1:0] inv_shiftrows(input logic [block_width-1:0] d);
    logic [word_width-1:0] w0;
    logic [word_width-1:0] w1;
    logic [word_width-1:0] w2;
    logic [word_width-1:0] w3;
    w0 = d[127:96];
    w1 = d[95:64];
    w2 = d[63:32];
    w3 = d[31:0];
    inv_shiftrows = {w0[31:24], w3[23:16], w2[15:8], w1[7:0],
                     w1[31:24], w0[23:16], w3[15:8], w2[7:0],
                     w2[31:24], w1[23:16], w0[15:8], w3[7:0],
                     w3[31:24], w2[23:16], w1[15:8], w0[7:0]};
  endfunction

  function automatic logic [block_width-1:0] add_round_key(input logic [block_width-1:0] d,
                                                           input logic [block_width-1:0] k);
    add_round_key = d ^ k;
  endfunction

  // state words, index 0 is the msb column
  logic [word_width-1:0]  block_w [4];
  logic [block_width-1:0] old_block;
  logic [block_width-1:0] block_new;
  logic [3:0]             word_we;
  logic [word_width-1:0]  sbox_in;
  logic [word_width-1:0]  sbox_out;

  assign old_block = {block_w[0], block_w[1], block_w[2], block_w[3]};
  assign new_block = old_block;

  // word under substitution
  assign sbox_in = block_w[sword];

  inv_sbox_word inv_sbox_word_i (
    .sboxw     (sbox_in),
    .new_sboxw (sbox_out)
  );

  //--------------------------------------------------------------------
  // next block value and word write enables
  //--------------------------------------------------------------------
  always_comb
  begin
    block_new = '0;
    word_we   = 4'h0;
    case (update)
      upd_init:
      begin
        block_new = inv_shiftrows(add_round_key(block_msg, round_key));
        word_we   = 4'hf;
      end
      upd_sbox:
      begin
        // only the selected word is written
        block_new      = {4{sbox_out}};
        word_we[sword] = 1'b1;
      end
      upd_main:
      begin
        block_new = inv_shiftrows(inv_mixcolumns(add_round_key(old_block, round_key)));
        word_we   = 4'hf;
      end
      upd_final:
      begin
        block_new = add_round_key(old_block, round_key);
        word_we   = 4'hf;
      end
      default:
      begin
        // idle, hold
        word_we = 4'h0;
      end
    endcase
  end

  // state register, zeroize wipes the block
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < 4; i++)
        block_w[i] <= '0;
    end
    else if (zeroize)
    begin
      for (int i = 0; i < 4; i++)
        block_w[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
        if (word_we[i])
          block_w[i] <= block_new[(3-i)*word_width +: word_width];
    end
  end

  // message must be settled in the init cycle after acceptance
  init_msg_known: assert property (@(posedge clk) disable iff (!reset_n)
    (update == upd_init) |-> !$isunknown(block_msg));

endmodule

//--- source/inv_round_ctrl.sv
//----------------------------------------------------------------------
// decipher sequencing fsm
// round counter, s-box word counter and ready flag
// update command decode from state and round count
//----------------------------------------------------------------------

`timescale 1ns/1ps

module inv_round_ctrl
  import aes_inv_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   zeroize,
  input  logic                   next_cmd,
  input  logic                   keylen,
  output logic                   ready,
  output logic [round_width-1:0] round,
  output update_t                update,
  output logic [1:0]             sword
);

  ctrl_state_t            state_reg;
  ctrl_state_t            state_new;
  logic [round_width-1:0] round_reg;
  logic [round_width-1:0] round_new;
  logic [1:0]             sword_reg;
  logic [1:0]             sword_new;
  logic                   ready_reg;
  logic                   ready_new;

  assign ready = ready_reg;
  assign round = round_reg;
  assign sword = sword_reg;

  //--------------------------------------------------------------------
  // next state and command decode
  //--------------------------------------------------------------------
  always_comb
  begin
    state_new = state_reg;
    round_new = round_reg;
    sword_new = sword_reg;
    ready_new = ready_reg;
    update    = upd_none;
    case (state_reg)
      ctrl_idle:
      begin
        // accept only here, next_cmd is ignored while busy
        if (next_cmd)
        begin
          round_new = (keylen == key_256) ? rounds_256 : rounds_128;
          ready_new = 1'b0;
          state_new = ctrl_init;
        end
      end
      ctrl_init:
      begin
        // key n applied here
        update    = upd_init;
        sword_new = 2'h0;
        state_new = ctrl_sbox;
      end
      ctrl_sbox:
      begin
        // one word per cycle, wraps back to 0 after word 3
        update    = upd_sbox;
        sword_new = sword_reg + 2'h1;
        if (sword_reg == 2'h3)
        begin
          round_new = round_reg - 1'b1;
          state_new = ctrl_main;
        end
      end
      ctrl_main:
      begin
        sword_new = 2'h0;
        if (round_reg != '0)
        begin
          update    = upd_main;
          state_new = ctrl_sbox;
        end
        else
        begin
          // last key add, result valid at the closing edge
          update    = upd_final;
          ready_new = 1'b1;
          state_new = ctrl_idle;
        end
      end
      default:
      begin
        state_new = ctrl_idle;
      end
    endcase
  end

  //--------------------------------------------------------------------
  // control registers
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg <= ctrl_idle;
      round_reg <= '0;
      sword_reg <= 2'h0;
      ready_reg <= 1'b1;
    end
    else if (zeroize)
    begin
      // back to the reset condition, any run in flight is dropped
      state_reg <= ctrl_idle;
      round_reg <= '0;
      sword_reg <= 2'h0;
      ready_reg <= 1'b1;
    end
    else
    begin
      state_reg <= state_new;
      round_reg <= round_new;
      sword_reg <= sword_new;
      ready_reg <= ready_new;
    end
  end

  // ready flag tracks the idle state on every edge
  ready_is_idle: assert property (@(posedge clk) disable iff (!reset_n)
    ready_reg == (state_reg == ctrl_idle));

  // datapath is never told to write while ready is shown
  idle_no_update: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> (update == upd_none));

  // counter stays within the long key range
  round_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    round_reg <= rounds_256);

endmodule

//--- source/aes_inv_cipher_core.sv
//----------------------------------------------------------------------
// block decipher core top level
// sequencing controller and round datapath
//----------------------------------------------------------------------

`timescale 1ns/1ps

module aes_inv_cipher_core
  import aes_inv_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   zeroize,
  input  logic                   next_cmd,
  input  logic                   keylen,
  input  logic [block_width-1:0] round_key,
  input  logic [block_width-1:0] block_msg,
  output logic [round_width-1:0] round,
  output logic [block_width-1:0] new_block,
  output logic                   ready
);

  // controller to datapath
  update_t    update;
  logic [1:0] sword;

  inv_round_ctrl inv_round_ctrl_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .zeroize  (zeroize),
    .next_cmd (next_cmd),
    .keylen   (keylen),
    .ready    (ready),
    .round    (round),
    .update   (update),
    .sword    (sword)
  );

  // round key for the current round comes back from outside
  inv_round_datapath inv_round_datapath_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .update    (update),
    .sword     (sword),
    .round_key (round_key),
    .block_msg (block_msg),
    .new_block (new_block)
  );

endmodule

//--- sim/aes_inv_model.svh
//----------------------------------------------------------------------
// reference model for the block decipher core
// inverse s-box table, row unshift, column unmix, byte unsubstitute
// full decipher over an array of round keys
//----------------------------------------------------------------------

`ifndef aes_inv_model_svh
`define aes_inv_model_svh

// one key per round index, 0 to 14
typedef logic [block_width-1:0] key_array_t [15];

logic [byte_width-1:0] ref_sbox [0:255];

task automatic load_sbox_table();
  $readmemh(sbox_file, ref_sbox);
endtask

// bytes counted from the msb, column c holds bytes 4c to 4c+3
function automatic logic [block_width-1:0] unshift_rows(input logic [block_width-1:0] d);
  logic [block_width-1:0] q;
  q = '0;
  for (int c = 0; c < 4; c++)
  begin
    for (int r = 0; r < 4; r++)
    begin
      // row r moves right by r columns
      q[(15 - 4*c - r)*8 +: 8] = d[(15 - 4*((c + 4 - r) % 4) - r)*8 +: 8];
    end
  end
  return q;
endfunction

// shift-and-add multiply in gf(2^8)
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
      p = p ^ x;
    x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
  end
  return p;
endfunction

// circulant matrix with first row 14 11 13 9
function automatic logic [block_width-1:0] unmix_columns(input logic [block_width-1:0] d);
  logic [block_width-1:0] q;
  logic [7:0]             coef [4];
  logic [7:0]             acc;
  coef[0] = 8'd14;
  coef[1] = 8'd11;
  coef[2] = 8'd13;
  coef[3] = 8'd9;
  q = '0;
  for (int c = 0; c < 4; c++)
  begin
    for (int r = 0; r < 4; r++)
    begin
      acc = 8'h00;
      for (int k = 0; k < 4; k++)
        acc = acc ^ gf_mul(coef[(k + 4 - r) % 4], d[(15 - 4*c - k)*8 +: 8]);
      q[(15 - 4*c - r)*8 +: 8] = acc;
    end
  end
  return q;
endfunction

// all sixteen bytes through the table, same as four word passes
function automatic logic [block_width-1:0] unsub_bytes(input logic [block_width-1:0] d);
  logic [block_width-1:0] q;
  for (int i = 0; i < 16; i++)
    q[i*8 +: 8] = ref_sbox[d[i*8 +: 8]];
  return q;
endfunction

// initial round, n-1 middle rounds, then the last s-box and key add
function automatic logic [block_width-1:0] decipher_block(input logic [block_width-1:0] blk,
                                                          input key_array_t keys,
                                                          input int n);
  logic [block_width-1:0] s;
  s = unshift_rows(blk ^ keys[n]);
  for (int r = n - 1; r >= 1; r--)
  begin
    s = unsub_bytes(s);
    s = unshift_rows(unmix_columns(s ^ keys[r]));
  end
  s = unsub_bytes(s);
  return s ^ keys[0];
endfunction

`endif

//--- sim/aes_inv_cipher_tb.sv
//----------------------------------------------------------------------
// testbench for the block decipher core
// clock, reset, round key store indexed by round
// stimulus table applied in a loop, checks against the reference model
//----------------------------------------------------------------------

`timescale 1ns/1ps

module aes_inv_cipher_tb
  import aes_inv_pkg::*;
();

  localparam int num_tests     = 8;
  localparam int done_timeout  = 200;
  localparam int ready_timeout = 100;

  // one row per command
  typedef struct packed {
    logic       keylen;
    logic       zero_data;
    logic       busy_pulse;
    logic [7:0] zeroize_at;
    logic [7:0] latency;
  } test_row_t;

  `include "aes_inv_model.svh"

  logic                   clk;
  logic                   reset_n;
  logic                   zeroize;
  logic                   next_cmd;
  logic                   keylen;
  logic [block_width-1:0] block_msg;
  logic [block_width-1:0] round_key;
  logic [round_width-1:0] round;
  logic [block_width-1:0] new_block;
  logic                   ready;

  key_array_t  key_store;
  test_row_t   test_table [num_tests];
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          failed_tests;
  bit          timed_out;

  // key store answers the round index in the same cycle
  assign round_key = key_store[round];

  aes_inv_cipher_core aes_inv_cipher_core_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .next_cmd  (next_cmd),
    .keylen    (keylen),
    .round_key (round_key),
    .block_msg (block_msg),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  always
  begin
    #20 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // random data and checks
  //--------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [block_width-1:0] random_block();
    logic [block_width-1:0] b;
    for (int i = 0; i < 4; i++)
    begin
      rng_state = xorshift32(rng_state);
      b[i*32 +: 32] = rng_state;
    end
    return b;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("mismatch %s: got %0h expected %0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic fill_table();
    // keylen, zero data, busy pulse, zeroize cycle, latency
    test_table[0] = '{1'b0, 1'b0, 1'b0, 8'd0, 8'd51};
    test_table[1] = '{1'b1, 1'b0, 1'b0, 8'd0, 8'd71};
    test_table[2] = '{1'b0, 1'b1, 1'b0, 8'd0, 8'd51};
    test_table[3] = '{1'b1, 1'b1, 1'b0, 8'd0, 8'd71};
    test_table[4] = '{1'b0, 1'b0, 1'b1, 8'd0, 8'd51};
    test_table[5] = '{1'b1, 1'b0, 1'b1, 8'd0, 8'd71};
    test_table[6] = '{1'b0, 1'b0, 1'b0, 8'd23, 8'd51};
    test_table[7] = '{1'b1, 1'b0, 1'b0, 8'd40, 8'd71};
  endtask

  //--------------------------------------------------------------------
  // handshake helpers, all entered at a falling edge
  //--------------------------------------------------------------------
  task automatic wait_ready();
    int count;
    count = 0;
    while (!ready && count < ready_timeout)
    begin
      @(negedge clk);
      count++;
    end
    if (!ready)
    begin
      $display("timeout: core stayed busy for %0d cycles before a command", ready_timeout);
      timed_out = 1'b1;
      error_count++;
    end
  endtask

  // keys and block go out one edge before the accepting edge
  task automatic start_command(input logic kl, input logic [block_width-1:0] blk,
                               input key_array_t keys, input int n);
    @(posedge clk);
    keylen    <= kl;
    block_msg <= blk;
    next_cmd  <= 1'b1;
    for (int i = 0; i < 15; i++)
      key_store[i] <= keys[i];
    @(posedge clk);
    next_cmd <= 1'b0;
    @(negedge clk);
    check_value("ready", ready, 0);
    check_value("round", round, n);
  endtask

  // counts edges after the accepting edge until ready is back
  task automatic wait_done(input logic busy_pulse, output int cycles);
    cycles = 0;
    while (!ready && cycles < done_timeout)
    begin
      @(posedge clk);
      cycles++;
      if (busy_pulse && cycles == 10)
      begin
        // stray command and new message while busy
        next_cmd  <= 1'b1;
        block_msg <= ~block_msg;
      end
      else if (busy_pulse && cycles == 13)
        next_cmd <= 1'b0;
      @(negedge clk);
    end
    if (!ready)
    begin
      $display("timeout: ready did not return within %0d cycles", done_timeout);
      timed_out = 1'b1;
      error_count++;
    end
  endtask

  // run into the middle of a command, then wipe the core
  task automatic abort_with_zeroize(input int at_cycle);
    for (int i = 1; i <= at_cycle; i++)
    begin
      @(posedge clk);
      @(negedge clk);
    end
    check_value("ready", ready, 0);
    @(posedge clk);
    zeroize <= 1'b1;
    @(posedge clk);
    zeroize <= 1'b0;
    @(negedge clk);
    check_value("ready", ready, 1);
    check_value("round", round, 0);
    check_value("new_block", new_block, 0);
  endtask

  //--------------------------------------------------------------------
  // one table row
  //--------------------------------------------------------------------
  task automatic run_test(input int idx);
    test_row_t              row;
    key_array_t             keys;
    logic [block_width-1:0] blk;
    logic [block_width-1:0] expected;
    int                     n;
    int                     cycles;
    int                     errors_before;
    row           = test_table[idx];
    errors_before = error_count;
    n             = (row.keylen == key_256) ? 14 : 10;
    blk           = row.zero_data ? '0 : random_block();
    for (int i = 0; i < 15; i++)
      keys[i] = row.zero_data ? '0 : random_block();
    expected = decipher_block(blk, keys, n);
    wait_ready();
    if (timed_out)
      return;
    if (row.zeroize_at != 0)
    begin
      start_command(row.keylen, blk, keys, n);
      abort_with_zeroize(row.zeroize_at);
    end
    // same command again, must complete as if nothing happened
    start_command(row.keylen, blk, keys, n);
    wait_done(row.busy_pulse, cycles);
    if (timed_out)
      return;
    check_value("latency", cycles, row.latency);
    check_value("new_block", new_block, expected);
    if (error_count != errors_before)
      failed_tests++;
    $display("test %0d keylen %0d latency %0d: %s", idx, row.keylen, cycles,
             (error_count == errors_before) ? "ok" : "errors");
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial
  begin
    int reset_errors;
    clk       = 1'b0;
    reset_n   = 1'b0;
    zeroize   = 1'b0;
    next_cmd  = 1'b0;
    keylen    = 1'b0;
    block_msg = '0;
    for (int i = 0; i < 15; i++)
      key_store[i] = '0;
    rng_state    = 32'hb3849785;
    error_count  = 0;
    check_count  = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    load_sbox_table();
    fill_table();

    // reset over four rising edges
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    reset_errors = error_count;
    check_value("ready", ready, 1);
    check_value("round", round, 0);
    check_value("new_block", new_block, 0);
    if (error_count != reset_errors)
      failed_tests++;
    $display("test reset: %s", (error_count == reset_errors) ? "ok" : "errors");

    for (int t = 0; t < num_tests && !timed_out; t++)
      run_test(t);

    $display("tests %0d, failing %0d, checks %0d, errors %0d",
             num_tests + 1, failed_tests, check_count, error_count);
    if (error_count == 0 && !timed_out)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- source/inv_sbox.hex
// inverse s-box bytes, row is the high nibble of the index, column the low nibble
52 09 6a d5 30 36 a5 38 bf 40 a3 9e 81 f3 d7 fb
7c e3 39 82 9b 2f ff 87 34 8e 43 44 c4 de e9 cb
54 7b 94 32 a6 c2 23 3d ee 4c 95 0b 42 fa c3 4e
08 2e a1 66 28 d9 24 b2 76 5b a2 49 6d 8b d1 25
72 f8 f6 64 86 68 98 16 d4 a4 5c cc 5d 65 b6 92
6c 70 48 50 fd ed b9 da 5e 15 46 57 a7 8d 9d 84
90 d8 ab 00 8c bc d3 0a f7 e4 58 05 b8 b3 45 06
d0 2c 1e 8f ca 3f 0f 02 c1 af bd 03 01 13 8a 6b
3a 91 11 41 4f 67 dc ea 97 f2 cf ce f0 b4 e6 73
96 ac 74 22 e7 ad 35 85 e2 f9 37 e8 1c 75 df 6e
47 f1 1a 71 1d 29 c5 89 6f b7 62 0e aa 18 be 1b
fc 56 3e 4b c6 d2 79 20 9a db c0 fe 78 cd 5a f4
1f dd a8 33 88 07 c7 31 b1 12 10 59 27 80 ec 5f
60 51 7f a9 19 b5 4a 0d 2d e5 7a 9f 93 c9 9c ef
a0 e0 3b 4d ae 2a f5 b0 c8 eb bb 3c 83 53 99 61
17 2b 04 7e ba 77 d6 26 e1 69 14 63 55 21 0c 7d

//--- aes_inv_cipher.f
+incdir+sim
source/aes_inv_pkg.sv
source/inv_sbox_word.sv
source/inv_round_datapath.sv
source/inv_round_ctrl.sv
source/aes_inv_cipher_core.sv
sim/aes_inv_cipher_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the block decipher testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f aes_inv_cipher.f \
  --top-module aes_inv_cipher_tb \
  -Mdir obj_dir -o aes_inv_cipher_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/aes_inv_cipher_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

cat sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
